// ==== source/covPkg.sv ====
`default_nettype none

package covPkg;

	localparam int sampleWidth = 26;
	localparam int sampleFrac = 9; // binary point position of each sample.
	localparam int productWidth = 2 * sampleWidth;
	localparam int covWidth = 16;
	localparam int numChannels = 4;

	localparam int windowLen = 128;
	localparam int countWidth = $clog2(windowLen + 1); // must be able to hold windowLen itself.

	// dividing by the window length and dropping the product's fraction bits
	// collapse into one arithmetic shift.
	localparam int covShift = $clog2(windowLen) + 2 * sampleFrac;

	typedef logic signed [sampleWidth-1:0] sample_t;
	typedef logic signed [productWidth-1:0] product_t;
	typedef logic signed [covWidth-1:0] covElem_t;

	typedef struct packed {
		sample_t x1;
		sample_t x2;
		sample_t x3;
		sample_t x4;
	} sampleVec_t;

	// Upper triangle only, the lower half is the same by symmetry.
	typedef struct packed {
		product_t p11;
		product_t p12;
		product_t p13;
		product_t p14;
		product_t p22;
		product_t p23;
		product_t p24;
		product_t p33;
		product_t p34;
		product_t p44;
	} productSet_t;

	typedef struct packed {
		covElem_t c11;
		covElem_t c12;
		covElem_t c13;
		covElem_t c14;
		covElem_t c21;
		covElem_t c22;
		covElem_t c23;
		covElem_t c24;
		covElem_t c31;
		covElem_t c32;
		covElem_t c33;
		covElem_t c34;
		covElem_t c41;
		covElem_t c42;
		covElem_t c43;
		covElem_t c44;
	} covMatrix_t;

endpackage

`default_nettype wire

// ==== source/sampleProducts.sv ====
`timescale 1ns/10ps
`default_nettype none

module sampleProducts (
	input wire logic clk,
	input wire logic rstN,
	input wire logic en,
	input wire covPkg::sampleVec_t samples,
	output covPkg::productSet_t products,
	output logic prodEn
);
	import covPkg::*;

	sample_t ch [numChannels];
	productSet_t prodNext;

	// indexed view of the incoming vector, so the products below read as ch[i] * ch[j].
	assign ch[0] = samples.x1;
	assign ch[1] = samples.x2;
	assign ch[2] = samples.x3;
	assign ch[3] = samples.x4;

	// Both operands are signed and the result is productWidth wide,
	// so each multiply is a full signed product with no loss.
	always_comb begin
		prodNext.p11 = ch[0] * ch[0];
		prodNext.p12 = ch[0] * ch[1];
		prodNext.p13 = ch[0] * ch[2];
		prodNext.p14 = ch[0] * ch[3];
		prodNext.p22 = ch[1] * ch[1];
		prodNext.p23 = ch[1] * ch[2];
		prodNext.p24 = ch[1] * ch[3];
		prodNext.p33 = ch[2] * ch[2];
		prodNext.p34 = ch[2] * ch[3];
		prodNext.p44 = ch[3] * ch[3];
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			prodEn <= 1'b0;
		end else begin
			prodEn <= en; // in step with the products captured on the same edge.
		end
	end

	// a new set of products is captured on every enabled edge.
	always_ff @(posedge clk) begin
		if (en) begin
			products <= prodNext;
		end
	end

	// the accumulator relies on prodEn tagging the products captured on the previous edge.
	prodEnTracksEn: assert property (
		@(posedge clk) $past(rstN) |-> prodEn == $past(en)
	) else $error("prodEn is not en delayed by one cycle.");

endmodule

`default_nettype wire

// ==== source/covAccumulator.sv ====
`timescale 1ns/10ps
`default_nettype none

module covAccumulator (
	input wire logic clk,
	input wire logic rstN,
	input wire logic prodEn,
	input wire covPkg::productSet_t products,
	output covPkg::covMatrix_t cov,
	output logic covValid
);
	import covPkg::*;

	productSet_t sums; // one running sum per unique product.
	logic [countWidth-1:0] count;
	logic windowEnd;

	// scale a window sum down to one output element.
	// Bits above covWidth are dropped, the result is not saturated.
	function automatic covElem_t scaleSum(input product_t sum);
		product_t shifted;
		shifted = sum >>> covShift;
		return shifted[covWidth-1:0];
	endfunction

	// A full window is in the sums once the count reaches windowLen.
	// The product present on that edge belongs to no window and is dropped.
	assign windowEnd = prodEn && (count == countWidth'(windowLen));

	always_ff @(posedge clk) begin
		if (!rstN) begin
			count <= '0;
			sums <= '0;
		end else if (!prodEn || windowEnd) begin
			count <= '0; // a gap in the stream restarts the window.
			sums <= '0;
		end else begin
			count <= count + 1'b1;
			sums.p11 <= sums.p11 + products.p11;
			sums.p12 <= sums.p12 + products.p12;
			sums.p13 <= sums.p13 + products.p13;
			sums.p14 <= sums.p14 + products.p14;
			sums.p22 <= sums.p22 + products.p22;
			sums.p23 <= sums.p23 + products.p23;
			sums.p24 <= sums.p24 + products.p24;
			sums.p33 <= sums.p33 + products.p33;
			sums.p34 <= sums.p34 + products.p34;
			sums.p44 <= sums.p44 + products.p44;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			covValid <= 1'b0;
			cov <= '0;
		end else begin
			covValid <= windowEnd;
			if (windowEnd) begin
				cov.c11 <= scaleSum(sums.p11);
				cov.c12 <= scaleSum(sums.p12);
				cov.c13 <= scaleSum(sums.p13);
				cov.c14 <= scaleSum(sums.p14);

				cov.c21 <= scaleSum(sums.p12); // lower triangle mirrors the upper sums.
				cov.c22 <= scaleSum(sums.p22);
				cov.c23 <= scaleSum(sums.p23);
				cov.c24 <= scaleSum(sums.p24);

				cov.c31 <= scaleSum(sums.p13);
				cov.c32 <= scaleSum(sums.p23);
				cov.c33 <= scaleSum(sums.p33);
				cov.c34 <= scaleSum(sums.p34);

				cov.c41 <= scaleSum(sums.p14);
				cov.c42 <= scaleSum(sums.p24);
				cov.c43 <= scaleSum(sums.p34);
				cov.c44 <= scaleSum(sums.p44);
			end
		end
	end

	// the count stops at windowLen and wraps to zero on the publish edge.
	countInRange: assert property (
		@(posedge clk) disable iff (!rstN) count <= countWidth'(windowLen)
	) else $error("window count ran past the window length.");

	// Windows are at least windowLen + 1 cycles apart, so a result never lasts two cycles.
	validIsPulse: assert property (
		@(posedge clk) disable iff (!rstN) covValid |=> !covValid
	) else $error("covValid stayed high for more than one cycle.");

	validAfterFullWindow: assert property (
		@(posedge clk) disable iff (!rstN) covValid |-> $past(count) == countWidth'(windowLen)
	) else $error("covValid without a full window behind it.");

endmodule

`default_nettype wire

// ==== source/covEstimator.sv ====
`timescale 1ns/10ps
`default_nettype none

module covEstimator (
	input wire logic clk,
	input wire logic rstN,
	input wire logic en,
	input wire covPkg::sampleVec_t samples,
	output covPkg::covMatrix_t cov,
	output logic covValid
);
	import covPkg::*;

	productSet_t products;
	logic prodEn; // marks the products that are valid this cycle.

	// One cycle of multiply, then the windowed sum.
	// The first result appears one cycle after edge 129 of the stream.
	sampleProducts productStage (
		.clk(clk),
		.rstN(rstN),
		.en(en),
		.samples(samples),
		.products(products),
		.prodEn(prodEn)
	);

	covAccumulator accumulator (
		.clk(clk),
		.rstN(rstN),
		.prodEn(prodEn),
		.products(products),
		.cov(cov),
		.covValid(covValid)
	);

endmodule

`default_nettype wire

// ==== verif/tbClockGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbClockGen (
	output logic clk,
	output logic rstN
);
	localparam time halfPeriod = 50ns;
	localparam int resetCycles = 4;

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#2 rstN = 1'b1; // released with the same offset as the stimulus.
	end

endmodule

`default_nettype wire

// ==== verif/covChecker.sv ====
`timescale 1ns/10ps
`default_nettype none

module covChecker (
	input wire logic clk,
	input wire logic rstN,
	input wire logic en,
	input wire covPkg::sampleVec_t samples,
	input wire covPkg::covMatrix_t cov,
	input wire logic covValid,
	output int windowsSeen,
	output int mismatches,
	output int protocolErrors
);
	import covPkg::*;

	typedef logic signed [covWidth-1:0] matrix_t [numChannels][numChannels];

	longint sums [numChannels][numChannels]; // full 4x4 model, symmetric by construction.
	int count;
	matrix_t stage1Mat;
	matrix_t stage2Mat;
	matrix_t lastMat;
	logic stage1Valid;
	logic stage2Valid;

	// element (i, j) sits at row-major position i * 4 + j, with c11 in the top bits.
	function automatic logic signed [covWidth-1:0] elementAt(input covMatrix_t m, input int i,
			input int j);
		int pos;
		pos = numChannels * numChannels - 1 - (i * numChannels + j);
		return m[pos * covWidth +: covWidth];
	endfunction

	task automatic clearModel();
		for (int i = 0; i < numChannels; i++) begin
			for (int j = 0; j < numChannels; j++) begin
				sums[i][j] = 0;
			end
		end
		count = 0;
	endtask

	task automatic compareMatrix(input matrix_t want, input string what);
		logic signed [covWidth-1:0] got;
		for (int i = 0; i < numChannels; i++) begin
			for (int j = 0; j < numChannels; j++) begin
				got = elementAt(cov, i, j);
				if (got !== want[i][j]) begin
					$display("FAILED at %0t: %s c%0d%0d is %0d, expected %0d", $time, what,
						i + 1, j + 1, got, want[i][j]);
					mismatches++;
				end
			end
		end
	endtask

	task automatic checkSymmetry();
		for (int i = 0; i < numChannels; i++) begin
			for (int j = i + 1; j < numChannels; j++) begin
				if (elementAt(cov, i, j) !== elementAt(cov, j, i)) begin
					$display("FAILED at %0t: c%0d%0d differs from c%0d%0d", $time, i + 1, j + 1,
						j + 1, i + 1);
					mismatches++;
				end
			end
		end
	endtask

	task automatic checkOutputs();
		if (covValid === 1'b1 && !stage2Valid) begin
			$display("covValid pulsed at %0t with no window end behind it.", $time);
			protocolErrors++;
		end else if (covValid !== 1'b1 && stage2Valid) begin
			$display("covValid missing at %0t after a full window.", $time);
			protocolErrors++;
		end else if (covValid !== 1'b0 && covValid !== 1'b1) begin
			$display("covValid is unknown at %0t.", $time);
			protocolErrors++;
		end
		if (covValid === 1'b1) begin
			windowsSeen++;
			checkSymmetry();
			if (stage2Valid) begin
				compareMatrix(stage2Mat, "window result");
				lastMat = stage2Mat;
			end else begin
				for (int i = 0; i < numChannels; i++) begin
					for (int j = 0; j < numChannels; j++) begin
						lastMat[i][j] = elementAt(cov, i, j); // so a stray pulse is reported once.
					end
				end
			end
		end else begin
			compareMatrix(lastMat, "held value");
		end
	endtask

	// the inputs seen here are taken at the next rising edge.
	// A closed window shows on covValid two negative edges later.
	task automatic advanceModel();
		longint v [numChannels];
		longint scaled;
		stage2Valid = stage1Valid;
		stage2Mat = stage1Mat;
		stage1Valid = 1'b0;
		if (en !== 1'b1) begin
			clearModel();
		end else if (count == windowLen) begin
			for (int i = 0; i < numChannels; i++) begin
				for (int j = 0; j < numChannels; j++) begin
					scaled = sums[i][j] >>> covShift;
					stage1Mat[i][j] = scaled[covWidth-1:0];
				end
			end
			stage1Valid = 1'b1;
			clearModel(); // this sample only closes the window.
		end else begin
			v[0] = longint'(samples.x1);
			v[1] = longint'(samples.x2);
			v[2] = longint'(samples.x3);
			v[3] = longint'(samples.x4);
			for (int i = 0; i < numChannels; i++) begin
				for (int j = 0; j < numChannels; j++) begin
					sums[i][j] += v[i] * v[j];
				end
			end
			count++;
		end
	endtask

	always @(negedge clk) begin
		if (!rstN) begin
			clearModel();
			stage1Valid = 1'b0;
			stage2Valid = 1'b0;
			for (int i = 0; i < numChannels; i++) begin
				for (int j = 0; j < numChannels; j++) begin
					lastMat[i][j] = '0;
				end
			end
			windowsSeen = 0;
			mismatches = 0;
			protocolErrors = 0;
		end else begin
			checkOutputs();
			advanceModel();
		end
	end

endmodule

`default_nettype wire

// ==== verif/covEstimatorTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module covEstimatorTb;
	import covPkg::*;

	typedef struct packed {
		logic isRandom;
		sampleVec_t level; // channel values used when the row is not random.
		int numSamples;
		int idleCycles;
		int windows; // covValid pulses the row must produce.
	} stimRow_t;

	localparam int numRows = 9;
	localparam int resetWaitLimit = 20;
	localparam int windowWaitLimit = 8;

	logic clk;
	logic rstN;
	logic en;
	sampleVec_t samples;
	covMatrix_t cov;
	logic covValid;
	int windowsSeen;
	int mismatches;
	int protocolErrors;
	int timeouts;
	int seed;
	int expectedWindows;
	stimRow_t stimTable [numRows];

	tbClockGen clockGen (
		.clk(clk),
		.rstN(rstN)
	);

	covEstimator UUT (
		.clk(clk),
		.rstN(rstN),
		.en(en),
		.samples(samples),
		.cov(cov),
		.covValid(covValid)
	);

	covChecker resultChecker (
		.clk(clk),
		.rstN(rstN),
		.en(en),
		.samples(samples),
		.cov(cov),
		.covValid(covValid),
		.windowsSeen(windowsSeen),
		.mismatches(mismatches),
		.protocolErrors(protocolErrors)
	);

	function automatic stimRow_t makeRow(input logic isRandom, input sample_t a, input sample_t b,
			input sample_t c, input sample_t d, input int numSamples, input int idleCycles,
			input int windows);
		stimRow_t row;
		row.isRandom = isRandom;
		row.level.x1 = a;
		row.level.x2 = b;
		row.level.x3 = c;
		row.level.x4 = d;
		row.numSamples = numSamples;
		row.idleCycles = idleCycles;
		row.windows = windows;
		return row;
	endfunction

	function automatic sampleVec_t randomVector();
		sampleVec_t vec;
		int r;
		r = $random(seed);
		vec.x1 = r[sampleWidth-1:0];
		r = $random(seed);
		vec.x2 = r[sampleWidth-1:0];
		r = $random(seed);
		vec.x3 = r[sampleWidth-1:0];
		r = $random(seed);
		vec.x4 = r[sampleWidth-1:0];
		return vec;
	endfunction

	// levels are Q16.9, so 26'sd1536 is 3.0.
	// A window needs 129 enabled samples, the last one only closes it.
	task automatic fillTable();
		stimTable[0] = makeRow(1'b0, '0, '0, '0, '0, 0, 8, 0);
		stimTable[1] = makeRow(1'b0, 26'sd1536, 26'sd1280, 26'sd51328, 26'sd384, 129, 3, 1);
		stimTable[2] = makeRow(1'b0, -26'sd1536, -26'sd51328, 26'sd10240256, -26'sd12345678,
			129, 3, 1);
		stimTable[3] = makeRow(1'b1, '0, '0, '0, '0, 387, 3, 3);
		stimTable[4] = makeRow(1'b1, '0, '0, '0, '0, 60, 2, 0);
		stimTable[5] = makeRow(1'b1, '0, '0, '0, '0, 129, 3, 1);
		stimTable[6] = makeRow(1'b0, -26'sd1536, -26'sd51328, 26'sd10240256, -26'sd12345678,
			128, 2, 0);
		stimTable[7] = makeRow(1'b1, '0, '0, '0, '0, 200, 3, 1);
		stimTable[8] = makeRow(1'b0, 26'sd1536, 26'sd1280, 26'sd51328, 26'sd384, 258, 4, 2);
	endtask

	task automatic driveCycle(input logic enable, input sampleVec_t vec);
		@(posedge clk);
		#2;
		en = enable;
		samples = vec;
	endtask

	task automatic waitForReset();
		int cycles;
		cycles = 0;
		while (rstN !== 1'b1 && cycles < resetWaitLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (rstN !== 1'b1) begin
			$display("timeout: reset was never released.");
			timeouts++;
		end
	endtask

	task automatic waitForWindows(input int rowIndex);
		int cycles;
		cycles = 0;
		while (windowsSeen < expectedWindows && cycles < windowWaitLimit) begin
			@(posedge clk);
			cycles++;
		end
		if (windowsSeen < expectedWindows) begin
			$display("timeout: row %0d, covValid pulse %0d did not arrive within %0d cycles.",
				rowIndex, windowsSeen + 1, windowWaitLimit);
			timeouts++;
		end
	endtask

	task automatic applyRow(input int rowIndex);
		stimRow_t row;
		row = stimTable[rowIndex];
		for (int i = 0; i < row.numSamples; i++) begin
			if (row.isRandom) begin
				driveCycle(1'b1, randomVector());
			end else begin
				driveCycle(1'b1, row.level);
			end
		end
		driveCycle(1'b0, '0);
		expectedWindows += row.windows;
		waitForWindows(rowIndex);
		repeat (row.idleCycles) driveCycle(1'b0, '0);
	endtask

	initial begin
		en = 1'b0;
		samples = '0;
		seed = 97389;
		timeouts = 0;
		expectedWindows = 0;
		fillTable();
		waitForReset();
		for (int r = 0; r < numRows; r++) begin
			applyRow(r);
		end
		repeat (4) driveCycle(1'b0, '0);
		$display("mismatches: %0d, protocol errors: %0d, timeouts: %0d", mismatches,
			protocolErrors, timeouts);
		if (mismatches + protocolErrors + timeouts == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
source/covPkg.sv
source/sampleProducts.sv
source/covAccumulator.sv
source/covEstimator.sv
verif/tbClockGen.sv
verif/covChecker.sv
verif/covEstimatorTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= covEstimatorTb
OBJ_DIR ?= obj_dir
FILELIST ?= compile.f
VFLAGS ?= --binary --assert -Wno-fatal -j 0
PASS_MSG ?= No errors

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass message appears as a line of its own.
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
